/* poker_params.svh */
`ifndef POKER_PARAMS_SVH
`define POKER_PARAMS_SVH

// chip amounts, 98 chips in play fit in 7 bits
`define POKER_MONEY_W       7
`define POKER_START_BALANCE 49
`define POKER_BET_STEP      5

`define POKER_NUM_PLAYERS   2
`define POKER_HANDS_W       8

// apb register map, byte offsets
`define POKER_ADDR_W        4
`define POKER_REG_ACTION    4'h0
`define POKER_REG_STATUS    4'h4
`define POKER_REG_STACKS    4'h8
`define POKER_REG_POT       4'hC

`endif

/* poker_pkg.sv */
`include "poker_params.svh"

package poker_pkg;

    typedef enum logic [1:0] {
        ACT_NEW_GAME   = 2'd0,
        ACT_FOLD       = 2'd1,
        ACT_CHECK_CALL = 2'd2,
        ACT_BET_RAISE  = 2'd3
    } action_e;

    typedef enum logic [1:0] {
        RND_PREFLOP = 2'd0,
        RND_FLOP    = 2'd1,
        RND_TURN    = 2'd2,
        RND_RIVER   = 2'd3
    } round_e;

    // OUT_RESET only travels on settle, it marks a new game
    typedef enum logic [1:0] {
        OUT_P1_WINS = 2'd0,
        OUT_P2_WINS = 2'd1,
        OUT_TIE     = 2'd2,
        OUT_RESET   = 2'd3
    } outcome_e;

    typedef struct packed {
        logic     valid;
        action_e  action;
        outcome_e outcome;
    } action_req_t;

    typedef struct packed {
        logic                       pay_call;
        logic                       pay_raise;
        logic                       clear_round;
        logic [`POKER_MONEY_W-1:0]  cur_bet;
    } stake_cmd_t;

    typedef struct packed {
        logic [`POKER_MONEY_W-1:0]  balance;
        logic [`POKER_MONEY_W-1:0]  betted;
        logic [`POKER_MONEY_W-1:0]  debit;
        logic                       can_call;
        logic                       can_raise;
    } stack_status_t;

    typedef struct packed {
        logic     valid;
        logic     showdown;
        logic     folder;
        outcome_e outcome;
    } settle_t;

endpackage

/* bet_apb_regs.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module bet_apb_regs (
    input  logic                                          clk,
    input  logic                                          reset_d,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [`POKER_ADDR_W-1:0]                      paddr,
    input  logic [31:0]                                   pwdata,
    output logic [31:0]                                   prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output poker_pkg::action_req_t                        req,
    input  logic                                          accept,
    input  poker_pkg::round_e                             round,
    input  logic                                          cur_player,
    input  logic [`POKER_HANDS_W-1:0]                     hands,
    input  poker_pkg::stack_status_t [`POKER_NUM_PLAYERS-1:0] stacks,
    input  logic [`POKER_MONEY_W-1:0]                     pot,
    input  logic [`POKER_MONEY_W-1:0]                     cur_bet
);
    import poker_pkg::*;

    logic        setup;
    logic        access;
    logic        action_hit;
    logic [31:0] rdata;

    assign setup      = psel && !penable;
    assign access     = psel && penable;
    assign action_hit = (paddr == `POKER_REG_ACTION);
    assign pready     = 1'b1;

    // action and outcome follow pwdata through both phases, so the
    // sequencer's accept is already valid during setup
    always_comb begin
        req.valid   = access && pwrite && action_hit;
        req.action  = action_e'(pwdata[1:0]);
        req.outcome = outcome_e'(pwdata[3:2]);
    end

    always_comb begin
        case (paddr)
            `POKER_REG_STATUS: begin
                rdata = {16'd0, hands, 3'd0, cur_player, 2'd0, round};
            end
            `POKER_REG_STACKS: begin
                rdata = {17'd0, stacks[1].balance, 1'b0, stacks[0].balance};
            end
            `POKER_REG_POT: begin
                rdata = {17'd0, cur_bet, 1'b0, pot};
            end
            default: begin
                rdata = 32'd0;
            end
        endcase
    end

    // registered at the setup edge so both are valid for the whole access phase
    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && pwrite && (!action_hit || !accept);
            if (setup && !pwrite) begin
                prdata <= rdata;
            end
        end
    end

    // error response only lands in the cycle the host samples it
    a_pslverr_in_access: assert property (
        @(posedge clk) disable iff (reset_d)
        pslverr |-> (psel && penable)
    ) else $error("pslverr raised outside the access phase");

endmodule

/* betting_sequencer.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module betting_sequencer (
    input  logic                                          clk,
    input  logic                                          reset_d,
    input  poker_pkg::action_req_t                        req,
    output logic                                          accept,
    input  poker_pkg::stack_status_t [`POKER_NUM_PLAYERS-1:0] stacks,
    output poker_pkg::stake_cmd_t    [`POKER_NUM_PLAYERS-1:0] cmds,
    output poker_pkg::settle_t                            settle,
    output poker_pkg::round_e                             round,
    output logic                                          cur_player,
    output logic [`POKER_HANDS_W-1:0]                     hands,
    output logic [`POKER_MONEY_W-1:0]                     cur_bet
);
    import poker_pkg::*;

    stack_status_t                act;
    logic                         fire;
    logic                         pay_call;
    logic                         pay_raise;
    logic                         clear_round;
    logic                         start_player;
    settle_t                      settle_c;
    round_e                       round_n;
    logic                         player_n;
    logic [`POKER_HANDS_W-1:0]    hands_n;
    logic [`POKER_MONEY_W-1:0]    bet_n;
    logic [`POKER_NUM_PLAYERS-1:0] pay_vec;

    assign act          = stacks[cur_player];
    assign start_player = hands[0];
    assign fire         = req.valid && accept;

    always_comb begin
        accept      = 1'b0;
        pay_call    = 1'b0;
        pay_raise   = 1'b0;
        clear_round = 1'b0;
        settle_c    = '0;
        round_n     = round;
        player_n    = cur_player;
        hands_n     = hands;
        bet_n       = cur_bet;
        case (req.action)
            ACT_NEW_GAME: begin
                accept           = 1'b1;
                settle_c.valid   = 1'b1;
                settle_c.outcome = OUT_RESET;
                round_n          = RND_PREFLOP;
                player_n         = 1'b0;
                hands_n          = '0;
                bet_n            = '0;
            end
            ACT_FOLD: begin
                accept          = 1'b1;
                clear_round     = 1'b1;
                settle_c.valid  = 1'b1;
                settle_c.folder = cur_player;
            end
            ACT_CHECK_CALL: begin
                if (cur_bet == '0) begin
                    accept = 1'b1;
                    if (cur_player == start_player) begin
                        player_n = !cur_player;
                    end else begin
                        clear_round = 1'b1;
                    end
                end else begin
                    accept      = act.can_call;
                    pay_call    = 1'b1;
                    clear_round = 1'b1;
                end
            end
            default: begin
                accept    = act.can_raise;
                pay_raise = 1'b1;
                bet_n     = cur_bet + `POKER_MONEY_W'(`POKER_BET_STEP);
                player_n  = !cur_player;
            end
        endcase

        // a closing round or a fold ends the betting for this round
        if (clear_round) begin
            bet_n = '0;
            if (req.action == ACT_FOLD || round == RND_RIVER) begin
                if (req.action != ACT_FOLD) begin
                    settle_c.valid    = 1'b1;
                    settle_c.showdown = 1'b1;
                    // the spare code never reaches the ledger as a result
                    settle_c.outcome  = (req.outcome == OUT_RESET) ? OUT_TIE : req.outcome;
                end
                hands_n  = hands + 1'b1;
                round_n  = RND_PREFLOP;
                player_n = hands_n[0];
            end else begin
                round_n  = round_e'(round + 2'd1);
                player_n = start_player;
            end
        end
    end

    for (genvar i = 0; i < `POKER_NUM_PLAYERS; i++) begin : g_cmd
        always_comb begin
            cmds[i].pay_call    = fire && pay_call && (cur_player == i);
            cmds[i].pay_raise   = fire && pay_raise && (cur_player == i);
            cmds[i].clear_round = fire && clear_round;
            cmds[i].cur_bet     = cur_bet;
        end
        // a stack that pays shows a nonzero debit
        assign pay_vec[i] = (stacks[i].debit != '0);
    end

    always_comb begin
        settle       = settle_c;
        settle.valid = fire && settle_c.valid;
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            round      <= RND_PREFLOP;
            cur_player <= 1'b0;
            hands      <= '0;
            cur_bet    <= '0;
        end else if (fire) begin
            round      <= round_n;
            cur_player <= player_n;
            hands      <= hands_n;
            cur_bet    <= bet_n;
        end
    end

    a_single_payer: assert property (
        @(posedge clk) disable iff (reset_d)
        $onehot0(pay_vec)
    ) else $error("more than one stack paid in a cycle");

endmodule

/* player_stack.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module player_stack (
    input  logic                        clk,
    input  logic                        reset_d,
    input  poker_pkg::stake_cmd_t       cmd,
    input  logic [`POKER_MONEY_W-1:0]   credit,
    input  logic                        restart,
    output poker_pkg::stack_status_t    status
);
    import poker_pkg::*;

    logic [`POKER_MONEY_W-1:0] balance;
    logic [`POKER_MONEY_W-1:0] betted;
    logic [`POKER_MONEY_W-1:0] call_cost;
    logic [`POKER_MONEY_W-1:0] raise_cost;
    logic [`POKER_MONEY_W-1:0] debit;

    // betted never exceeds the open bet
    assign call_cost  = cmd.cur_bet - betted;
    assign raise_cost = call_cost + `POKER_MONEY_W'(`POKER_BET_STEP);
    assign debit      = cmd.pay_call  ? call_cost  :
                        cmd.pay_raise ? raise_cost : '0;

    always_comb begin
        status.balance   = balance;
        status.betted    = betted;
        status.debit     = debit;
        status.can_call  = (balance >= call_cost);
        status.can_raise = (balance >= raise_cost);
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            balance <= `POKER_MONEY_W'(`POKER_START_BALANCE);
            betted  <= '0;
        end else if (restart) begin
            balance <= `POKER_MONEY_W'(`POKER_START_BALANCE);
            betted  <= '0;
        end else begin
            balance <= balance - debit + credit;
            if (cmd.clear_round) begin
                betted <= '0;
            end else begin
                betted <= betted + debit;
            end
        end
    end

    // a wrap would show up as a jump above the old balance plus credit
    a_no_wrap: assert property (
        @(posedge clk) disable iff (reset_d)
        (debit != '0 && !restart) |=> ({1'b0, balance} <= {1'b0, $past(balance)} + $past(credit))
    ) else $error("stack balance wrapped below zero");

endmodule

/* pot_ledger.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module pot_ledger (
    input  logic                                              clk,
    input  logic                                              reset_d,
    input  poker_pkg::stack_status_t [`POKER_NUM_PLAYERS-1:0] stacks,
    input  poker_pkg::settle_t                                settle,
    output logic [`POKER_MONEY_W-1:0]                         pot,
    output logic [`POKER_NUM_PLAYERS-1:0][`POKER_MONEY_W-1:0] credits,
    output logic                                              restart
);
    import poker_pkg::*;

    logic [`POKER_MONEY_W:0] pot_total;
    logic [`POKER_MONEY_W:0] credit_sum;

    // payout includes whatever is paid in the closing cycle
    always_comb begin
        pot_total  = {1'b0, pot};
        credit_sum = '0;
        for (int i = 0; i < `POKER_NUM_PLAYERS; i++) begin
            pot_total  = pot_total + stacks[i].debit;
            credit_sum = credit_sum + credits[i];
        end
    end

    always_comb begin
        credits = '0;
        restart = settle.valid && (settle.outcome == OUT_RESET);
        if (settle.valid && !restart) begin
            if (!settle.showdown) begin
                credits[!settle.folder] = pot_total[`POKER_MONEY_W-1:0];
            end else begin
                case (settle.outcome)
                    OUT_P1_WINS: credits[0] = pot_total[`POKER_MONEY_W-1:0];
                    OUT_P2_WINS: credits[1] = pot_total[`POKER_MONEY_W-1:0];
                    // odd chip is dropped on a split
                    default: begin
                        credits[0] = pot_total[`POKER_MONEY_W:1];
                        credits[1] = pot_total[`POKER_MONEY_W:1];
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            pot <= '0;
        end else begin
            pot <= settle.valid ? '0 : pot_total[`POKER_MONEY_W-1:0];
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset_d)
        credit_sum <= pot_total
    ) else $error("credits exceed pot plus incoming debits");

endmodule

/* poker_table.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module poker_table (
    input  logic                      clk,
    input  logic                      reset_d,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`POKER_ADDR_W-1:0]  paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import poker_pkg::*;

    action_req_t                                      req;
    logic                                             accept;
    stake_cmd_t    [`POKER_NUM_PLAYERS-1:0]           cmds;
    stack_status_t [`POKER_NUM_PLAYERS-1:0]           stacks;
    logic [`POKER_NUM_PLAYERS-1:0][`POKER_MONEY_W-1:0] credits;
    settle_t                                          settle;
    logic                                             restart;
    round_e                                           round;
    logic                                             cur_player;
    logic [`POKER_HANDS_W-1:0]                        hands;
    logic [`POKER_MONEY_W-1:0]                        cur_bet;
    logic [`POKER_MONEY_W-1:0]                        pot;

    bet_apb_regs u_regs (
        .clk(clk), .reset_d(reset_d),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .req(req), .accept(accept), .round(round), .cur_player(cur_player),
        .hands(hands), .stacks(stacks), .pot(pot), .cur_bet(cur_bet)
    );

    betting_sequencer u_seq (
        .clk(clk), .reset_d(reset_d), .req(req), .accept(accept), .stacks(stacks),
        .cmds(cmds), .settle(settle), .round(round), .cur_player(cur_player),
        .hands(hands), .cur_bet(cur_bet)
    );

    for (genvar i = 0; i < `POKER_NUM_PLAYERS; i++) begin : g_stack
        player_stack u_stack (
            .clk(clk), .reset_d(reset_d), .cmd(cmds[i]), .credit(credits[i]),
            .restart(restart), .status(stacks[i])
        );
    end

    pot_ledger u_ledger (
        .clk(clk), .reset_d(reset_d), .stacks(stacks), .settle(settle),
        .pot(pot), .credits(credits), .restart(restart)
    );

endmodule

/* tb_poker_checker.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module tb_poker_checker (
    input  logic                     clk,
    input  logic                     reset_d,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`POKER_ADDR_W-1:0] paddr,
    input  logic [31:0]              prdata,
    input  logic                     pready,
    input  logic                     pslverr,
    input  logic [31:0]              exp_status,
    input  logic [31:0]              exp_stacks,
    input  logic [31:0]              exp_pot,
    input  logic                     exp_err,
    input  logic                     test_done,
    output int                       err_count,
    output int                       check_count
);
    int          errs = 0;
    int          checks = 0;
    int          test_num = 0;
    int          test_errs = 0;
    int          test_checks = 0;
    logic [31:0] expected;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic string reg_name(logic [`POKER_ADDR_W-1:0] addr);
        case (addr)
            `POKER_REG_STATUS: return "STATUS";
            `POKER_REG_STACKS: return "STACKS";
            `POKER_REG_POT:    return "POT";
            default:           return "unmapped";
        endcase
    endfunction

    // access phase, prdata and pslverr hold their values from the setup edge
    always @(posedge clk) begin
        if (!reset_d && psel && penable) begin
            checks      = checks + 1;
            test_checks = test_checks + 1;
            if (!pready) begin
                $display("at %0t ns pready was low in the access phase, the slave never stalls",
                         $time);
                errs      = errs + 1;
                test_errs = test_errs + 1;
            end
            if (pwrite) begin
                if (exp_err && !pslverr) begin
                    $display("at %0t ns write to 0x%0h was not refused, pslverr stayed low",
                             $time, paddr);
                    errs      = errs + 1;
                    test_errs = test_errs + 1;
                end else if (!exp_err && pslverr) begin
                    $display("at %0t ns legal write to 0x%0h was refused with pslverr",
                             $time, paddr);
                    errs      = errs + 1;
                    test_errs = test_errs + 1;
                end
            end else begin
                case (paddr)
                    `POKER_REG_STATUS: expected = exp_status;
                    `POKER_REG_STACKS: expected = exp_stacks;
                    `POKER_REG_POT:    expected = exp_pot;
                    default:           expected = 32'd0;
                endcase
                if (prdata !== expected) begin
                    $display("[FAIL] %0t ns: %s read 0x%08h, expected 0x%08h",
                             $time, reg_name(paddr), prdata, expected);
                    errs      = errs + 1;
                    test_errs = test_errs + 1;
                end
                if (pslverr) begin
                    $display("at %0t ns a read of %s raised pslverr, reads never fail",
                             $time, reg_name(paddr));
                    errs      = errs + 1;
                    test_errs = test_errs + 1;
                end
            end
        end
        if (test_done) begin
            test_num = test_num + 1;
            $display("test %0d finished: %0d checks, %0d errors",
                     test_num, test_checks, test_errs);
            test_checks = 0;
            test_errs   = 0;
        end
    end

endmodule

/* tb_poker_table.sv */
`timescale 1ns/1ps
`include "poker_params.svh"

module tb_poker_table;
    import poker_pkg::*;

    localparam int DIRECTED_ACTIONS = 36;
    localparam int RANDOM_ACTIONS   = 200;
    localparam int MAX_CYCLES       = 40 * (DIRECTED_ACTIONS + RANDOM_ACTIONS + 1);

    typedef struct packed {
        logic                              refused;
        logic [1:0]                        round;
        logic                              player;
        logic [`POKER_HANDS_W-1:0]         hands;
        logic [1:0][`POKER_MONEY_W-1:0]    bal;
        logic [1:0][`POKER_MONEY_W-1:0]    betted;
        logic [`POKER_MONEY_W-1:0]         pot;
        logic [`POKER_MONEY_W-1:0]         bet;
    } model_t;

    logic                     clk;
    logic                     reset_d;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`POKER_ADDR_W-1:0] paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    model_t                   st;
    logic                     exp_err;
    logic                     test_done;
    logic [31:0]              exp_status;
    logic [31:0]              exp_stacks;
    logic [31:0]              exp_pot;
    int                       err_count;
    int                       check_count;
    int                       cycles = 0;
    integer                   seed;
    int                       pick;
    int                       pick_out;
    action_e                  rnd_act;
    outcome_e                 rnd_out;

    // register images of the model state
    assign exp_status = {16'd0, st.hands, 3'd0, st.player, 2'd0, st.round};
    assign exp_stacks = {17'd0, st.bal[1], 1'b0, st.bal[0]};
    assign exp_pot    = {17'd0, st.bet, 1'b0, st.pot};

    poker_table u_dut (
        .clk(clk), .reset_d(reset_d), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    tb_poker_checker u_chk (
        .clk(clk), .reset_d(reset_d), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .exp_status(exp_status), .exp_stacks(exp_stacks), .exp_pot(exp_pot),
        .exp_err(exp_err), .test_done(test_done), .err_count(err_count),
        .check_count(check_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic model_t start_state();
        model_t s;
        s = '0;
        s.bal[0] = `POKER_START_BALANCE;
        s.bal[1] = `POKER_START_BALANCE;
        return s;
    endfunction

    function automatic model_t poker_model(model_t s, action_e act, outcome_e outc);
        model_t                    n;
        logic                      p;
        logic [`POKER_MONEY_W-1:0] cost;
        logic                      close_round;
        logic                      hand_over;
        n           = s;
        n.refused   = 1'b0;
        p           = s.player;
        close_round = 1'b0;
        hand_over   = 1'b0;
        case (act)
            ACT_NEW_GAME: begin
                n = start_state();
            end
            ACT_FOLD: begin
                n.bal[!p] = s.bal[!p] + s.pot;
                n.pot     = '0;
                hand_over = 1'b1;
            end
            ACT_CHECK_CALL: begin
                if (s.bet == '0) begin
                    if (p == s.hands[0]) begin
                        n.player = !p;
                    end else begin
                        close_round = 1'b1;
                    end
                end else begin
                    cost = s.bet - s.betted[p];
                    if (s.bal[p] < cost) begin
                        n.refused = 1'b1;
                    end else begin
                        n.bal[p]    = s.bal[p] - cost;
                        n.pot       = s.pot + cost;
                        close_round = 1'b1;
                    end
                end
            end
            default: begin
                cost = s.bet - s.betted[p] + `POKER_BET_STEP;
                if (s.bal[p] < cost) begin
                    n.refused = 1'b1;
                end else begin
                    n.bal[p]    = s.bal[p] - cost;
                    n.betted[p] = s.betted[p] + cost;
                    n.pot       = s.pot + cost;
                    n.bet       = s.bet + `POKER_BET_STEP;
                    n.player    = !p;
                end
            end
        endcase
        if (close_round) begin
            if (s.round == RND_RIVER) begin
                // showdown pays the pot including the closing call
                case (outc)
                    OUT_P1_WINS: n.bal[0] = n.bal[0] + n.pot;
                    OUT_P2_WINS: n.bal[1] = n.bal[1] + n.pot;
                    default: begin
                        n.bal[0] = n.bal[0] + (n.pot >> 1);
                        n.bal[1] = n.bal[1] + (n.pot >> 1);
                    end
                endcase
                n.pot     = '0;
                hand_over = 1'b1;
            end else begin
                n.round  = s.round + 2'd1;
                n.player = s.hands[0];
            end
        end
        if (close_round || hand_over) begin
            n.betted = '0;
            n.bet    = '0;
        end
        if (hand_over) begin
            n.hands  = s.hands + 1'b1;
            n.round  = RND_PREFLOP;
            n.player = n.hands[0];
        end
        return n;
    endfunction

    task automatic apb_access(input logic [`POKER_ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic write);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_regs();
        apb_access(`POKER_REG_STATUS, 32'd0, 1'b0);
        apb_access(`POKER_REG_STACKS, 32'd0, 1'b0);
        apb_access(`POKER_REG_POT, 32'd0, 1'b0);
    endtask

    task automatic do_action(input action_e act, input outcome_e outc);
        model_t nxt;
        nxt     = poker_model(st, act, outc);
        exp_err = nxt.refused;
        apb_access(`POKER_REG_ACTION, {28'd0, outc, act}, 1'b1);
        exp_err     = 1'b0;
        nxt.refused = 1'b0;
        st          = nxt;
        check_regs();
    endtask

    task automatic bad_write();
        exp_err = 1'b1;
        apb_access(`POKER_REG_STATUS, {28'd0, OUT_TIE, ACT_FOLD}, 1'b1);
        exp_err = 1'b0;
        check_regs();
    endtask

    task automatic finish_test();
        @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = 32'd0;
        reset_d   = 1'b1;
        exp_err   = 1'b0;
        test_done = 1'b0;
        seed      = 9716;
        st        = start_state();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_d = 1'b0;

        // reset values
        check_regs();
        finish_test();

        // check-check through all four rounds, empty pot split
        repeat (8) do_action(ACT_CHECK_CALL, OUT_TIE);
        finish_test();

        // hand with player 2 starting, betting on the flop, player 1 wins
        repeat (2) do_action(ACT_CHECK_CALL, OUT_P1_WINS);
        do_action(ACT_BET_RAISE, OUT_P1_WINS);
        do_action(ACT_BET_RAISE, OUT_P1_WINS);
        repeat (5) do_action(ACT_CHECK_CALL, OUT_P1_WINS);
        // next hand ends in a split of the pot
        do_action(ACT_BET_RAISE, OUT_TIE);
        repeat (5) do_action(ACT_CHECK_CALL, OUT_TIE);
        do_action(ACT_BET_RAISE, OUT_TIE);
        do_action(ACT_CHECK_CALL, OUT_TIE);
        finish_test();

        // fold after a bet
        do_action(ACT_BET_RAISE, OUT_TIE);
        do_action(ACT_FOLD, OUT_TIE);
        finish_test();

        // raising war until one side runs short, then a bad offset
        repeat (8) do_action(ACT_BET_RAISE, OUT_TIE);
        bad_write();
        finish_test();

        for (int i = 0; i < RANDOM_ACTIONS; i++) begin
            pick     = $unsigned($random(seed)) % 16;
            pick_out = $unsigned($random(seed)) % 3;
            if (pick == 0) begin
                rnd_act = ACT_NEW_GAME;
            end else if (pick < 3) begin
                rnd_act = ACT_FOLD;
            end else if (pick < 10) begin
                rnd_act = ACT_CHECK_CALL;
            end else begin
                rnd_act = ACT_BET_RAISE;
            end
            if (pick_out == 0) begin
                rnd_out = OUT_P1_WINS;
            end else if (pick_out == 1) begin
                rnd_out = OUT_P2_WINS;
            end else begin
                rnd_out = OUT_TIE;
            end
            do_action(rnd_act, rnd_out);
        end
        do_action(ACT_NEW_GAME, OUT_TIE);
        finish_test();

        @(negedge clk);
        $display("all tests done: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
poker_pkg.sv
bet_apb_regs.sv
betting_sequencer.sv
player_stack.sv
pot_ledger.sv
poker_table.sv
tb_poker_checker.sv
tb_poker_table.sv
